//--- rtl/decode_params.svh
`ifndef DECODE_PARAMS_SVH
`define DECODE_PARAMS_SVH

// Opcode byte
`define OPCODE_W        8

// ALU operation code
`define ALU_OP_W        5

// Addressing mode code
`define ADDR_MODE_W     4

// Instruction length in bytes, 1 to 3
`define INSTR_SIZE_W    2

`define INSTR_TYPE_W    8   // Instruction class
`define REG_DEST_W      3   // Destination register

`endif

//--- rtl/decode_pkg.sv
package decode_pkg;

`include "decode_params.svh"

        // Same byte seen as a table key and as the aaa/bbb/cc opcode groups
        typedef union packed {
                logic [`OPCODE_W-1:0] raw;
                struct packed {
                        logic [2:0] aaa;        // Operation within the group
                        logic [2:0] bbb;        // Addressing pattern
                        logic [1:0] cc;         // Opcode group
                } fields;
        } opcode_u;

        typedef enum logic [`ADDR_MODE_W-1:0] {
                AM_IMPL = 4'd0,                 // Implied or accumulator
                AM_IMM  = 4'd1,                 // Immediate, also branch offset
                AM_ZP   = 4'd2,
                AM_ABS  = 4'd3,
                AM_ZPX  = 4'd4,
                AM_ZPY  = 4'd5,
                AM_ABX  = 4'd6,
                AM_ABY  = 4'd7,
                AM_INDX = 4'd8,                 // (zp,X)
                AM_INDY = 4'd9                  // (zp),Y
        } addr_mode_e;

        typedef enum logic [`INSTR_TYPE_W-1:0] {
                I_LDA = 8'd0, I_STA, I_ADC, I_SBC, I_AND, I_JMP, I_INX, I_ORA,
                I_XOR, I_INC, I_ASL, I_LSR, I_ROL, I_ROR,
                I_BEQ, I_BNE, I_BCS, I_BCC, I_BMI, I_BPL, I_BVC, I_BVS,
                I_TA, I_TX, I_TY, I_TS,         // Transfers, by source register
                I_CMP, I_CPX, I_CPY,
                I_SET_CARRY, I_CLR_CARRY, I_SET_IRQ, I_CLR_IRQ,
                I_SET_DEC, I_CLR_DEC, I_CLR_OVF,
                I_BIT = 8'd36
        } instr_type_e;

        typedef enum logic [`ALU_OP_W-1:0] {
                ALU_PASS = 5'd0,
                ALU_ADD,
                ALU_SUB,                        // Also used by compares
                ALU_AND,                        // Also used by BIT
                ALU_OR,
                ALU_XOR,
                ALU_ASL,
                ALU_LSR,
                ALU_ROL,
                ALU_ROR,
                ALU_INC,
                ALU_DEC
        } alu_op_e;

        typedef enum logic [`REG_DEST_W-1:0] {
                DEST_NONE = 3'd0,
                DEST_A    = 3'd1,
                DEST_X    = 3'd2,
                DEST_Y    = 3'd3,
                DEST_MEM  = 3'd4,               // Read-modify-write result
                DEST_SP   = 3'd5,
                DEST_PS   = 3'd6                // Status flags only
        } reg_dest_e;

endpackage

//--- rtl/addr_mode_decoder.sv
`include "decode_params.svh"

module addr_mode_decoder (
        input  decode_pkg::opcode_u         opcode,
        output decode_pkg::addr_mode_e      addr_mode,
        output logic [`INSTR_SIZE_W-1:0]    instr_size
);

        import decode_pkg::*;

        logic       known;              // Opcode is in the table
        addr_mode_e pattern_mode;       // Mode from bbb/cc alone

        always_comb begin
                case (opcode.raw)
                8'h05, 8'h06, 8'h09, 8'h0A, 8'h0E, 8'h10, 8'h16, 8'h18, 8'h1E,
                8'h21, 8'h24, 8'h25, 8'h29, 8'h2A, 8'h2C, 8'h2D, 8'h30, 8'h31,
                8'h35, 8'h38, 8'h39, 8'h3D,
                8'h45, 8'h46, 8'h49, 8'h4A, 8'h4C, 8'h4E, 8'h50, 8'h56, 8'h58,
                8'h5E,
                8'h61, 8'h65, 8'h69, 8'h6A, 8'h6D, 8'h70, 8'h71, 8'h75, 8'h78,
                8'h79, 8'h7D,
                8'h81, 8'h84, 8'h85, 8'h86, 8'h88, 8'h8A, 8'h8C, 8'h8D, 8'h8E,
                8'h90, 8'h91, 8'h94, 8'h95, 8'h96, 8'h98, 8'h99, 8'h9A, 8'h9D,
                8'hA0, 8'hA1, 8'hA2, 8'hA4, 8'hA5, 8'hA6, 8'hA8, 8'hA9, 8'hAA,
                8'hAC, 8'hAD, 8'hAE, 8'hB0, 8'hB1, 8'hB4, 8'hB5, 8'hB6, 8'hB8,
                8'hB9, 8'hBA, 8'hBC, 8'hBD, 8'hBE,
                8'hC0, 8'hC4, 8'hC5, 8'hC6, 8'hC8, 8'hC9, 8'hCA, 8'hD0, 8'hD8,
                8'hE0, 8'hE4, 8'hE6, 8'hE8, 8'hE9, 8'hEA, 8'hF0, 8'hF8:
                        known = 1'b1;
                default:
                        known = 1'b0;
                endcase
        end

        // Regular layout of the two opcode groups
        always_comb begin
                if (opcode.fields.cc == 2'b01) begin
                        case (opcode.fields.bbb)
                        3'd0:    pattern_mode = AM_INDX;
                        3'd1:    pattern_mode = AM_ZP;
                        3'd2:    pattern_mode = AM_IMM;
                        3'd3:    pattern_mode = AM_ABS;
                        3'd4:    pattern_mode = AM_INDY;
                        3'd5:    pattern_mode = AM_ZPX;
                        3'd6:    pattern_mode = AM_ABY;
                        default: pattern_mode = AM_ABX;
                        endcase
                end else begin
                        case (opcode.fields.bbb)
                        3'd0:    pattern_mode = AM_IMM;
                        3'd1:    pattern_mode = AM_ZP;
                        3'd3:    pattern_mode = AM_ABS;
                        3'd5:    pattern_mode = AM_ZPX;
                        3'd7:    pattern_mode = AM_ABX;
                        default: pattern_mode = AM_IMPL;
                        endcase
                end
        end

        always_comb begin
                addr_mode = pattern_mode;
                if (opcode.fields.cc == 2'b00 && opcode.fields.bbb == 3'd4)
                        addr_mode = AM_IMM;             // Branches carry an offset byte
                if (opcode.fields.cc == 2'b10 && opcode.fields.aaa inside {3'd4, 3'd5}) begin
                        // STX and LDX index with Y instead of X
                        if (opcode.fields.bbb == 3'd5)
                                addr_mode = AM_ZPY;
                        else if (opcode.fields.bbb == 3'd7)
                                addr_mode = AM_ABY;
                end
                if (opcode.raw == 8'h4C)
                        addr_mode = AM_ABS;             // JMP absolute
                if (opcode.fields.bbb inside {3'd2, 3'd6} && opcode.fields.cc != 2'b01)
                        addr_mode = AM_IMPL;            // Accumulator, flag and transfer ops
                if (!known)
                        addr_mode = AM_IMPL;
        end

        always_comb begin
                case (addr_mode)
                AM_IMPL:                instr_size = 2'd1;
                AM_ABS, AM_ABX, AM_ABY: instr_size = 2'd3;  // Two address bytes
                default:                instr_size = 2'd2;
                endcase
        end

endmodule

//--- rtl/operation_decoder.sv
module operation_decoder (
        input  decode_pkg::opcode_u         opcode,
        output decode_pkg::instr_type_e     instr_type,
        output decode_pkg::alu_op_e         alu_op,
        output logic                        use_alu
);

        import decode_pkg::*;

        always_comb begin
                instr_type = I_LDA;
                alu_op     = ALU_PASS;
                case (opcode.raw)
                // LDA, LDX, LDY
                8'hA9, 8'hA5, 8'hB5, 8'hAD, 8'hBD, 8'hB9, 8'hA1, 8'hB1,
                8'hA2, 8'hA6, 8'hB6, 8'hAE, 8'hBE,
                8'hA0, 8'hA4, 8'hB4, 8'hAC, 8'hBC: begin
                        instr_type = I_LDA;
                        alu_op     = ALU_PASS;
                end
                // STA, STX, STY
                8'h85, 8'h95, 8'h8D, 8'h9D, 8'h99, 8'h81, 8'h91,
                8'h86, 8'h96, 8'h8E,
                8'h84, 8'h94, 8'h8C: begin
                        instr_type = I_STA;
                end
                8'h69, 8'h65, 8'h75, 8'h6D, 8'h7D, 8'h79, 8'h61, 8'h71: begin
                        instr_type = I_ADC;
                        alu_op     = ALU_ADD;
                end
                8'hE9: begin
                        instr_type = I_SBC;
                        alu_op     = ALU_SUB;
                end
                8'h29, 8'h25, 8'h35, 8'h2D, 8'h3D, 8'h39, 8'h21, 8'h31: begin
                        instr_type = I_AND;
                        alu_op     = ALU_AND;
                end
                8'h09, 8'h05: begin
                        instr_type = I_ORA;
                        alu_op     = ALU_OR;
                end
                8'h49, 8'h45: begin
                        instr_type = I_XOR;
                        alu_op     = ALU_XOR;
                end
                8'h24, 8'h2C: begin
                        instr_type = I_BIT;
                        alu_op     = ALU_AND;           // Flags from A and M
                end
                8'hC9, 8'hC5: begin
                        instr_type = I_CMP;
                        alu_op     = ALU_SUB;
                end
                8'hE0, 8'hE4: begin
                        instr_type = I_CPX;
                        alu_op     = ALU_SUB;
                end
                8'hC0, 8'hC4: begin
                        instr_type = I_CPY;
                        alu_op     = ALU_SUB;
                end
                8'h0A, 8'h06, 8'h16, 8'h0E, 8'h1E: begin
                        instr_type = I_ASL;
                        alu_op     = ALU_ASL;
                end
                8'h4A, 8'h46, 8'h56, 8'h4E, 8'h5E: begin
                        instr_type = I_LSR;
                        alu_op     = ALU_LSR;
                end
                8'h2A: begin
                        instr_type = I_ROL;
                        alu_op     = ALU_ROL;
                end
                8'h6A: begin
                        instr_type = I_ROR;
                        alu_op     = ALU_ROR;
                end
                8'hE6: begin
                        instr_type = I_INC;
                        alu_op     = ALU_INC;
                end
                8'hC6: begin
                        instr_type = I_INC;             // DEC shares the INC class
                        alu_op     = ALU_DEC;
                end
                8'hE8, 8'hC8: begin                     // INX, INY
                        instr_type = I_INX;
                        alu_op     = ALU_INC;
                end
                8'hCA, 8'h88: begin                     // DEX, DEY
                        instr_type = I_INX;
                        alu_op     = ALU_DEC;
                end
                8'hA8, 8'hAA: instr_type = I_TA;        // TAY, TAX
                8'h9A, 8'h8A: instr_type = I_TX;        // TXS, TXA
                8'h98:        instr_type = I_TY;
                8'hBA:        instr_type = I_TS;
                8'h38:        instr_type = I_SET_CARRY;
                8'h18:        instr_type = I_CLR_CARRY;
                8'h78:        instr_type = I_SET_IRQ;
                8'h58:        instr_type = I_CLR_IRQ;
                8'hF8:        instr_type = I_SET_DEC;
                8'hD8:        instr_type = I_CLR_DEC;
                8'hB8:        instr_type = I_CLR_OVF;
                8'h4C:        instr_type = I_JMP;
                8'hF0:        instr_type = I_BEQ;
                8'hD0:        instr_type = I_BNE;
                8'hB0:        instr_type = I_BCS;
                8'h90:        instr_type = I_BCC;
                8'h30:        instr_type = I_BMI;
                8'h10:        instr_type = I_BPL;
                8'h50:        instr_type = I_BVC;
                8'h70:        instr_type = I_BVS;
                default: begin
                        // NOP and undefined opcodes
                        instr_type = I_LDA;
                        alu_op     = ALU_PASS;
                end
                endcase
        end

        // Transfers pass the value through the ALU unchanged
        assign use_alu = (alu_op != ALU_PASS) ||
                         (instr_type inside {I_TA, I_TX, I_TY, I_TS});

endmodule

//--- rtl/operand_route_decoder.sv
module operand_route_decoder (
        input  decode_pkg::opcode_u         opcode,
        input  decode_pkg::addr_mode_e      addr_mode,
        output decode_pkg::reg_dest_e       reg_dest,
        output logic                        mem_read,
        output logic                        mem_write
);

        import decode_pkg::*;

        logic operand_rd;       // Instruction consumes an operand value
        logic operand_wr;       // Result or register goes to memory

        always_comb begin
                reg_dest   = DEST_NONE;
                operand_rd = 1'b0;
                operand_wr = 1'b0;
                case (opcode.raw)
                // Loads into A, then ADC/SBC/AND/ORA/XOR
                8'hA9, 8'hA5, 8'hB5, 8'hAD, 8'hBD, 8'hB9, 8'hA1, 8'hB1,
                8'h69, 8'h65, 8'h75, 8'h6D, 8'h7D, 8'h79, 8'h61, 8'h71,
                8'hE9, 8'h29, 8'h25, 8'h35, 8'h2D, 8'h3D, 8'h39, 8'h21, 8'h31,
                8'h09, 8'h05, 8'h49, 8'h45: begin
                        reg_dest   = DEST_A;
                        operand_rd = 1'b1;
                end
                8'hA2, 8'hA6, 8'hB6, 8'hAE, 8'hBE: begin
                        reg_dest   = DEST_X;
                        operand_rd = 1'b1;
                end
                8'hA0, 8'hA4, 8'hB4, 8'hAC, 8'hBC: begin
                        reg_dest   = DEST_Y;
                        operand_rd = 1'b1;
                end
                // Stores report the register they take data from
                8'h85, 8'h95, 8'h8D, 8'h9D, 8'h99, 8'h81, 8'h91: begin
                        reg_dest   = DEST_A;
                        operand_wr = 1'b1;
                end
                8'h86, 8'h96, 8'h8E: begin
                        reg_dest   = DEST_X;
                        operand_wr = 1'b1;
                end
                8'h84, 8'h94, 8'h8C: begin
                        reg_dest   = DEST_Y;
                        operand_wr = 1'b1;
                end
                8'hC9, 8'hC5, 8'hE0, 8'hE4, 8'hC0, 8'hC4, 8'h24, 8'h2C: begin
                        reg_dest   = DEST_PS;           // Compares and BIT
                        operand_rd = 1'b1;
                end
                // Memory shifts, INC and DEC
                8'h06, 8'h16, 8'h0E, 8'h1E, 8'h46, 8'h56, 8'h4E, 8'h5E,
                8'hE6, 8'hC6: begin
                        reg_dest   = DEST_MEM;
                        operand_rd = 1'b1;
                        operand_wr = 1'b1;
                end
                8'h38, 8'h18, 8'h78, 8'h58, 8'hF8, 8'hD8, 8'hB8:
                        reg_dest = DEST_PS;
                8'h0A, 8'h4A, 8'h2A, 8'h6A, 8'h8A, 8'h98:
                        reg_dest = DEST_A;              // Accumulator shifts, TXA, TYA
                8'hE8, 8'hCA, 8'hAA, 8'hBA:
                        reg_dest = DEST_X;
                8'hC8, 8'h88, 8'hA8:
                        reg_dest = DEST_Y;
                8'h9A:
                        reg_dest = DEST_SP;
                default:
                        reg_dest = DEST_NONE;           // JMP, branches, NOP
                endcase
        end

        // Immediate operand comes from the instruction stream
        assign mem_read  = operand_rd && !(addr_mode inside {AM_IMM, AM_IMPL});
        assign mem_write = operand_wr;

endmodule

//--- rtl/opcode_decoder.sv
`include "decode_params.svh"

module opcode_decoder (
        input  decode_pkg::opcode_u         opcode,
        output decode_pkg::alu_op_e         alu_op,
        output logic                        use_alu,
        output logic                        mem_read,
        output logic                        mem_write,
        output decode_pkg::addr_mode_e      addr_mode,
        output logic [`INSTR_SIZE_W-1:0]    instr_size,
        output decode_pkg::instr_type_e     instr_type,
        output decode_pkg::reg_dest_e       reg_dest
);

        // Mode also gates the memory read in the routing decoder
        addr_mode_decoder u_addr_mode (
                .opcode         (opcode),
                .addr_mode      (addr_mode),
                .instr_size     (instr_size)
        );

        operation_decoder u_operation (
                .opcode         (opcode),
                .instr_type     (instr_type),
                .alu_op         (alu_op),
                .use_alu        (use_alu)
        );

        operand_route_decoder u_route (
                .opcode         (opcode),
                .addr_mode      (addr_mode),
                .reg_dest       (reg_dest),
                .mem_read       (mem_read),
                .mem_write      (mem_write)
        );

endmodule

//--- testbench/decode_checker.sv
`include "decode_params.svh"

module decode_checker (
        input  logic                        clk,
        input  logic                        reset,
        input  logic                        check_en,
        input  logic [`OPCODE_W-1:0]        opcode,
        input  logic [`ALU_OP_W-1:0]        alu_op,
        input  logic                        use_alu,
        input  logic                        mem_read,
        input  logic                        mem_write,
        input  logic [`ADDR_MODE_W-1:0]     addr_mode,
        input  logic [`INSTR_SIZE_W-1:0]    instr_size,
        input  logic [`INSTR_TYPE_W-1:0]    instr_type,
        input  logic [`REG_DEST_W-1:0]      reg_dest,
        input  logic [`ALU_OP_W-1:0]        exp_alu_op,
        input  logic                        exp_use_alu,
        input  logic                        exp_mem_read,
        input  logic                        exp_mem_write,
        input  logic [`ADDR_MODE_W-1:0]     exp_addr_mode,
        input  logic [`INSTR_SIZE_W-1:0]    exp_instr_size,
        input  logic [`INSTR_TYPE_W-1:0]    exp_instr_type,
        input  logic [`REG_DEST_W-1:0]      exp_reg_dest,
        output int                          check_count,
        output int                          error_count
);

        // One field, returns 1 on a mismatch
        function automatic int compare_field(input string name, input logic [7:0] expected,
                                             input logic [7:0] actual);
                if (actual !== expected) begin
                        $display("FAILED at time %0t: opcode %02h field %s expected %0h got %0h",
                                 $time, opcode, name, expected, actual);
                        return 1;
                end
                return 0;
        endfunction

        function automatic int count_mismatches();
                int n;
                n = 0;
                n += compare_field("alu_op", 8'(exp_alu_op), 8'(alu_op));
                n += compare_field("use_alu", 8'(exp_use_alu), 8'(use_alu));
                n += compare_field("mem_read", 8'(exp_mem_read), 8'(mem_read));
                n += compare_field("mem_write", 8'(exp_mem_write), 8'(mem_write));
                n += compare_field("addr_mode", 8'(exp_addr_mode), 8'(addr_mode));
                n += compare_field("instr_size", 8'(exp_instr_size), 8'(instr_size));
                n += compare_field("instr_type", 8'(exp_instr_type), 8'(instr_type));
                n += compare_field("reg_dest", 8'(exp_reg_dest), 8'(reg_dest));
                return n;
        endfunction

        // Vector applied on the previous edge is sampled here
        always @(posedge clk) begin
                if (reset) begin
                        check_count <= 0;
                        error_count <= 0;
                end else if (check_en) begin
                        check_count <= check_count + 1;
                        error_count <= error_count + count_mismatches();
                end
        end

endmodule

//--- testbench/tb_opcode_decoder.sv
`include "decode_params.svh"

module tb_opcode_decoder;

        localparam int    MAX_LINES  = 256;
        localparam int    LINE_WORDS = 9;       // Opcode plus eight fields
        localparam int    RAND_COUNT = 64;
        localparam string STIM_FILE  = "testbench/decode_stim.txt";

        logic                       clk;
        logic                       reset;
        logic                       check_en;
        logic [`OPCODE_W-1:0]       opcode;
        logic [`ALU_OP_W-1:0]       alu_op;
        logic                       use_alu;
        logic                       mem_read;
        logic                       mem_write;
        logic [`ADDR_MODE_W-1:0]    addr_mode;
        logic [`INSTR_SIZE_W-1:0]   instr_size;
        logic [`INSTR_TYPE_W-1:0]   instr_type;
        logic [`REG_DEST_W-1:0]     reg_dest;
        logic [`ALU_OP_W-1:0]       exp_alu_op;
        logic                       exp_use_alu;
        logic                       exp_mem_read;
        logic                       exp_mem_write;
        logic [`ADDR_MODE_W-1:0]    exp_addr_mode;
        logic [`INSTR_SIZE_W-1:0]   exp_instr_size;
        logic [`INSTR_TYPE_W-1:0]   exp_instr_type;
        logic [`REG_DEST_W-1:0]     exp_reg_dest;
        int                         check_count;
        int                         error_count;

        logic [7:0]  stim_mem [0:MAX_LINES*LINE_WORDS-1];
        int          line_of [0:255];           // Record index per opcode, -1 if undefined
        int          n_lines;
        int          watchdog_limit;
        logic        table_ready;
        logic [15:0] lfsr;

        opcode_decoder u_dut (
                .opcode         (opcode),
                .alu_op         (alu_op),
                .use_alu        (use_alu),
                .mem_read       (mem_read),
                .mem_write      (mem_write),
                .addr_mode      (addr_mode),
                .instr_size     (instr_size),
                .instr_type     (instr_type),
                .reg_dest       (reg_dest)
        );

        decode_checker u_checker (
                .clk            (clk),
                .reset          (reset),
                .check_en       (check_en),
                .opcode         (opcode),
                .alu_op         (alu_op),
                .use_alu        (use_alu),
                .mem_read       (mem_read),
                .mem_write      (mem_write),
                .addr_mode      (addr_mode),
                .instr_size     (instr_size),
                .instr_type     (instr_type),
                .reg_dest       (reg_dest),
                .exp_alu_op     (exp_alu_op),
                .exp_use_alu    (exp_use_alu),
                .exp_mem_read   (exp_mem_read),
                .exp_mem_write  (exp_mem_write),
                .exp_addr_mode  (exp_addr_mode),
                .exp_instr_size (exp_instr_size),
                .exp_instr_type (exp_instr_type),
                .exp_reg_dest   (exp_reg_dest),
                .check_count    (check_count),
                .error_count    (error_count)
        );

        initial begin
                clk = 1'b0;
                forever #2 clk = ~clk;
        end

        // Every address byte folded into the fill
        function automatic logic [7:0] fill_byte(input int addr);
                return 8'(addr) ^ 8'(addr >> 8) ^ 8'(addr >> 16) ^ 8'(addr >> 24);
        endfunction

        // Unread words keep the address fill
        function automatic bit line_blank(input int n);
                int i;
                for (i = 0; i < LINE_WORDS; i++)
                        if (stim_mem[n * LINE_WORDS + i] != fill_byte(n * LINE_WORDS + i))
                                return 1'b0;
                return 1'b1;
        endfunction

        function automatic bit line_in_range(input int n);
                int b;
                b = n * LINE_WORDS;
                return stim_mem[b + 1] <= 8'h0B && stim_mem[b + 2] <= 8'h01 &&
                       stim_mem[b + 3] <= 8'h01 && stim_mem[b + 4] <= 8'h01 &&
                       stim_mem[b + 5] <= 8'h09 && stim_mem[b + 6] >= 8'h01 &&
                       stim_mem[b + 6] <= 8'h03 && stim_mem[b + 7] <= 8'h24 &&
                       stim_mem[b + 8] <= 8'h06;
        endfunction

        task automatic load_table(output bit ok);
                int i;
                int fd;
                ok = 1'b1;
                n_lines = 0;
                for (i = 0; i < 256; i++)
                        line_of[i] = -1;
                for (i = 0; i < MAX_LINES * LINE_WORDS; i++)
                        stim_mem[i] = fill_byte(i);
                fd = $fopen(STIM_FILE, "r");
                if (fd == 0) begin
                        $display("Stimulus file %s could not be opened", STIM_FILE);
                        ok = 1'b0;
                        return;
                end
                $fclose(fd);
                $readmemh(STIM_FILE, stim_mem);
                while (n_lines < MAX_LINES && !line_blank(n_lines)) begin
                        if (!line_in_range(n_lines) ||
                            line_of[stim_mem[n_lines * LINE_WORDS]] >= 0) begin
                                $display("Stimulus file %s is malformed at record %0d",
                                         STIM_FILE, n_lines + 1);
                                ok = 1'b0;
                                return;
                        end
                        line_of[stim_mem[n_lines * LINE_WORDS]] = n_lines;
                        n_lines++;
                end
                if (n_lines == 0) begin
                        $display("Stimulus file %s holds no records", STIM_FILE);
                        ok = 1'b0;
                end
        endtask

        function automatic logic [15:0] lfsr_step(input logic [15:0] state);
                if (state[0])
                        return (state >> 1) ^ 16'hB400;    // Taps 16, 14, 13, 11
                return state >> 1;
        endfunction

        task automatic next_random_byte(output logic [7:0] b);
                int i;
                b = 8'h00;
                for (i = 0; i < 8; i++) begin
                        lfsr = lfsr_step(lfsr);
                        b = {b[6:0], lfsr[0]};
                end
        endtask

        task automatic apply_vector(input logic [7:0] op);
                int base;
                base = line_of[op] * LINE_WORDS;
                @(posedge clk);
                opcode   <= op;
                check_en <= 1'b1;
                if (line_of[op] >= 0) begin
                        exp_alu_op     <= stim_mem[base + 1][`ALU_OP_W-1:0];
                        exp_use_alu    <= stim_mem[base + 2][0];
                        exp_mem_read   <= stim_mem[base + 3][0];
                        exp_mem_write  <= stim_mem[base + 4][0];
                        exp_addr_mode  <= stim_mem[base + 5][`ADDR_MODE_W-1:0];
                        exp_instr_size <= stim_mem[base + 6][`INSTR_SIZE_W-1:0];
                        exp_instr_type <= stim_mem[base + 7];
                        exp_reg_dest   <= stim_mem[base + 8][`REG_DEST_W-1:0];
                end else begin
                        // Default decode of an undefined opcode
                        exp_alu_op     <= '0;
                        exp_use_alu    <= 1'b0;
                        exp_mem_read   <= 1'b0;
                        exp_mem_write  <= 1'b0;
                        exp_addr_mode  <= '0;
                        exp_instr_size <= 2'd1;
                        exp_instr_type <= '0;
                        exp_reg_dest   <= '0;
                end
        endtask

        initial begin
                wait (table_ready);
                #(watchdog_limit);
                $display("Watchdog expired after %0d time units before the tests finished",
                         watchdog_limit);
                $display("TESTS FAILED");
                $finish;
        end

        initial begin
                bit         ok;
                int         i;
                logic [7:0] rand_op;
                reset = 1'b1;
                check_en = 1'b0;
                opcode = '0;
                exp_alu_op = '0;
                exp_use_alu = 1'b0;
                exp_mem_read = 1'b0;
                exp_mem_write = 1'b0;
                exp_addr_mode = '0;
                exp_instr_size = 2'd1;
                exp_instr_type = '0;
                exp_reg_dest = '0;
                lfsr = 16'd24;
                table_ready = 1'b0;
                load_table(ok);
                if (!ok) begin
                        $display("Run stopped without a usable stimulus table");
                        $display("TESTS FAILED");
                end else begin
                        watchdog_limit = (8 + n_lines + RAND_COUNT + 20) * 4;
                        table_ready = 1'b1;
                        repeat (8) @(posedge clk);
                        reset <= 1'b0;
                        for (i = 0; i < n_lines; i++)
                                apply_vector(stim_mem[i * LINE_WORDS]);
                        for (i = 0; i < RAND_COUNT; i++) begin
                                next_random_byte(rand_op);
                                apply_vector(rand_op);
                        end
                        @(posedge clk);
                        check_en <= 1'b0;
                        @(posedge clk);         // Last vector counted by now
                        $display("Decode checks: %0d vectors, %0d errors",
                                 check_count, error_count);
                        if (error_count == 0 && check_count == n_lines + RAND_COUNT) begin
                                $display("TESTS PASSED");
                        end else begin
                                if (check_count != n_lines + RAND_COUNT)
                                        $display("Checker saw %0d vectors instead of %0d",
                                                 check_count, n_lines + RAND_COUNT);
                                $display("TESTS FAILED");
                        end
                end
                $finish;
        end

endmodule

//--- testbench/decode_stim.txt
// opcode alu_op use_alu mem_read mem_write addr_mode instr_size instr_type reg_dest
// All hex, one defined opcode per line, field codes as in decode_pkg
05  04 1 1 0 2 2 07 1
06  06 1 1 1 2 2 0A 4
09  04 1 0 0 1 2 07 1
0A  06 1 0 0 0 1 0A 1
0E  06 1 1 1 3 3 0A 4
10  00 0 0 0 1 2 13 0
16  06 1 1 1 4 2 0A 4
18  00 0 0 0 0 1 1E 6
1E  06 1 1 1 6 3 0A 4
21  03 1 1 0 8 2 04 1
24  03 1 1 0 2 2 24 6
25  03 1 1 0 2 2 04 1
29  03 1 0 0 1 2 04 1
2A  08 1 0 0 0 1 0C 1
2C  03 1 1 0 3 3 24 6
2D  03 1 1 0 3 3 04 1
30  00 0 0 0 1 2 12 0
31  03 1 1 0 9 2 04 1
35  03 1 1 0 4 2 04 1
38  00 0 0 0 0 1 1D 6
39  03 1 1 0 7 3 04 1
3D  03 1 1 0 6 3 04 1
45  05 1 1 0 2 2 08 1
46  07 1 1 1 2 2 0B 4
49  05 1 0 0 1 2 08 1
4A  07 1 0 0 0 1 0B 1
4C  00 0 0 0 3 3 05 0
4E  07 1 1 1 3 3 0B 4
50  00 0 0 0 1 2 14 0
56  07 1 1 1 4 2 0B 4
58  00 0 0 0 0 1 20 6
5E  07 1 1 1 6 3 0B 4
61  01 1 1 0 8 2 02 1
65  01 1 1 0 2 2 02 1
69  01 1 0 0 1 2 02 1
6A  09 1 0 0 0 1 0D 1
6D  01 1 1 0 3 3 02 1
70  00 0 0 0 1 2 15 0
71  01 1 1 0 9 2 02 1
75  01 1 1 0 4 2 02 1
78  00 0 0 0 0 1 1F 6
79  01 1 1 0 7 3 02 1
7D  01 1 1 0 6 3 02 1
81  00 0 0 1 8 2 01 1
84  00 0 0 1 2 2 01 3
85  00 0 0 1 2 2 01 1
86  00 0 0 1 2 2 01 2
88  0B 1 0 0 0 1 06 3
8A  00 1 0 0 0 1 17 1
8C  00 0 0 1 3 3 01 3
8D  00 0 0 1 3 3 01 1
8E  00 0 0 1 3 3 01 2
90  00 0 0 0 1 2 11 0
91  00 0 0 1 9 2 01 1
94  00 0 0 1 4 2 01 3
95  00 0 0 1 4 2 01 1
96  00 0 0 1 5 2 01 2
98  00 1 0 0 0 1 18 1
99  00 0 0 1 7 3 01 1
9A  00 1 0 0 0 1 17 5
9D  00 0 0 1 6 3 01 1
A0  00 0 0 0 1 2 00 3
A1  00 0 1 0 8 2 00 1
A2  00 0 0 0 1 2 00 2
A4  00 0 1 0 2 2 00 3
A5  00 0 1 0 2 2 00 1
A6  00 0 1 0 2 2 00 2
A8  00 1 0 0 0 1 16 3
A9  00 0 0 0 1 2 00 1
AA  00 1 0 0 0 1 16 2
AC  00 0 1 0 3 3 00 3
AD  00 0 1 0 3 3 00 1
AE  00 0 1 0 3 3 00 2
B0  00 0 0 0 1 2 10 0
B1  00 0 1 0 9 2 00 1
B4  00 0 1 0 4 2 00 3
B5  00 0 1 0 4 2 00 1
B6  00 0 1 0 5 2 00 2
B8  00 0 0 0 0 1 23 6
B9  00 0 1 0 7 3 00 1
BA  00 1 0 0 0 1 19 2
BC  00 0 1 0 6 3 00 3
BD  00 0 1 0 6 3 00 1
BE  00 0 1 0 7 3 00 2
C0  02 1 0 0 1 2 1C 6
C4  02 1 1 0 2 2 1C 6
C5  02 1 1 0 2 2 1A 6
C6  0B 1 1 1 2 2 09 4
C8  0A 1 0 0 0 1 06 3
C9  02 1 0 0 1 2 1A 6
CA  0B 1 0 0 0 1 06 2
D0  00 0 0 0 1 2 0F 0
D8  00 0 0 0 0 1 22 6
E0  02 1 0 0 1 2 1B 6
E4  02 1 1 0 2 2 1B 6
E6  0A 1 1 1 2 2 09 4
E8  0A 1 0 0 0 1 06 2
E9  02 1 0 0 1 2 03 1
EA  00 0 0 0 0 1 00 0
F0  00 0 0 0 1 2 0E 0
F8  00 0 0 0 0 1 21 6

//--- flist.f
+incdir+rtl
rtl/decode_pkg.sv
rtl/addr_mode_decoder.sv
rtl/operation_decoder.sv
rtl/operand_route_decoder.sv
rtl/opcode_decoder.sv
testbench/decode_checker.sv
testbench/tb_opcode_decoder.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing
TOP       := tb_opcode_decoder
FLIST     := flist.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "TESTS PASSED" $(LOG); then echo "Simulation did not complete"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
